/* src/mips_exc_pkg.sv */
package mips_exc_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ALU,
        OP_LW,
        OP_LH,
        OP_LHU,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_SH,
        OP_SB,
        OP_SYSCALL,
        OP_BREAK,
        OP_ERET
    } decoded_op_t;

    typedef struct packed {
        logic memwrite;
        logic memtoreg;
    } ctl_t;

    typedef struct packed {
        decoded_op_t op;
        ctl_t        ctl;
    } instr_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
        word_t  pcplus4;
        word_t  result;             // alu result, also the data address
        logic   in_delay_slot;
        logic   exception_instr;    // fetch address error
        logic   instr_tlb_refill;
        logic   instr_tlb_invalid;
        logic   exception_ri;
        logic   exception_of;
    } exec_data_t;

    typedef struct packed {
        logic d_tlb_refill;
        logic d_tlb_invalid;
        logic d_tlb_modified;
    } tu_op_resp_t;

    typedef struct packed {
        logic instr;
        logic instr_tlb;
        logic ri;
        logic of;
        logic sys;
        logic bp;
        logic load;
        logic save;
        logic load_tlb;
        logic save_tlb;
        logic mod;
    } exc_info_t;

    typedef struct packed {
        exc_info_t   exc_info;
        logic        tlb_refill;
        logic        in_delay_slot;
        word_t       pc;
        word_t       vaddr;
        logic [7:0]  interrupt_info; // pending and unmasked
    } exception_pipeline_t;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_t;

    typedef struct packed {
        exc_code_t code;
        word_t     bad_vaddr;
        logic      has_bad_vaddr;
        word_t     pc;
        logic      in_delay_slot;
        logic      refill;
    } exception_t;

    typedef struct packed {
        logic       BEV;
        logic [7:0] IM;
        logic       EXL;
        logic       IE;
    } cp0_status_t;

    typedef struct packed {
        logic       BD;
        logic       TI;
        logic [7:0] IP;    // [1:0] software, [7:2] hardware
        exc_code_t  exc_code;
    } cp0_cause_t;

    typedef struct packed {
        logic       en;
        logic [4:0] addr;
        word_t      data;
    } cp0_write_t;

    typedef enum logic {
        CTL_RUN,
        CTL_FLUSH
    } ctl_state_t;

    parameter logic [4:0] REG_BADVADDR = 5'd8;
    parameter logic [4:0] REG_COUNT    = 5'd9;
    parameter logic [4:0] REG_COMPARE  = 5'd11;
    parameter logic [4:0] REG_STATUS   = 5'd12;
    parameter logic [4:0] REG_CAUSE    = 5'd13;
    parameter logic [4:0] REG_EPC      = 5'd14;

    parameter word_t VEC_BASE_BEV0 = 32'h8000_0000;
    parameter word_t VEC_BASE_BEV1 = 32'hbfc0_0200;
    parameter word_t OFS_GENERAL   = 32'h0000_0180;
    parameter word_t OFS_REFILL    = 32'h0000_0000;

endpackage

/* src/exception_prioritizer.sv */
module exception_prioritizer
    import mips_exc_pkg::*;
(
    input  exception_pipeline_t pipe,
    input  cp0_status_t         cp0_status,
    output logic                exception_valid,
    output word_t               pcexception,
    output exception_t          exception
);

    exc_info_t info;
    logic      int_taken;
    logic      tlb_code;
    word_t     base;
    word_t     offset;

    assign info      = pipe.exc_info;
    assign int_taken = cp0_status.IE & ~cp0_status.EXL & (pipe.interrupt_info != 8'd0);

    always_comb begin
        exception_valid = 1'b1;
        exception.code  = EXC_INT;
        if (int_taken) begin
            exception.code = EXC_INT;
        end else if (info.instr) begin
            exception.code = EXC_ADEL;
        end else if (info.instr_tlb) begin
            exception.code = EXC_TLBL;
        end else if (info.ri) begin
            exception.code = EXC_RI;
        end else if (info.of) begin
            exception.code = EXC_OV;
        end else if (info.sys) begin
            exception.code = EXC_SYS;
        end else if (info.bp) begin
            exception.code = EXC_BP;
        end else if (info.load) begin
            exception.code = EXC_ADEL;
        end else if (info.save) begin
            exception.code = EXC_ADES;
        end else if (info.load_tlb) begin
            exception.code = EXC_TLBL;
        end else if (info.save_tlb) begin
            exception.code = EXC_TLBS;
        end else if (info.mod) begin
            exception.code = EXC_MOD;
        end else begin
            exception_valid = 1'b0;
        end
    end

    // refill only counts when the winning fault is itself a tlb miss
    assign tlb_code = (exception.code == EXC_TLBL) || (exception.code == EXC_TLBS);

    assign exception.bad_vaddr     = pipe.vaddr;
    assign exception.has_bad_vaddr = exception_valid && (tlb_code ||
                                     exception.code == EXC_ADEL ||
                                     exception.code == EXC_ADES ||
                                     exception.code == EXC_MOD);
    assign exception.pc            = pipe.pc;
    assign exception.in_delay_slot = pipe.in_delay_slot;
    assign exception.refill        = exception_valid & tlb_code & pipe.tlb_refill;

    assign base        = cp0_status.BEV ? VEC_BASE_BEV1 : VEC_BASE_BEV0;
    assign offset      = (exception.refill && !cp0_status.EXL) ? OFS_REFILL : OFS_GENERAL;
    assign pcexception = base + offset;

endmodule

/* src/exception_checker.sv */
module exception_checker
    import mips_exc_pkg::*;
(
    input  logic        flush,
    input  exec_data_t  in,
    input  logic [5:0]  ext_int,
    input  logic        timer_interrupt,
    input  cp0_status_t cp0_status,
    input  cp0_cause_t  cp0_cause,
    input  tu_op_resp_t tu_op_resp,
    output logic        exception_valid,
    output word_t       pcexception,
    output exception_t  exception_data,
    output exec_data_t  out,
    output logic        eret_valid
);

    exception_pipeline_t pipe;
    logic                raw_valid;
    word_t               raw_vector;
    exception_t          raw_exception;

    decoded_op_t op;
    word_t       addr;
    logic        take;
    logic        is_read;
    logic        is_write;
    logic        bus_en;
    logic        fetch_fault;

    assign op   = in.instr.op;
    assign addr = in.result;
    assign take = in.valid & ~flush;   // instruction really present this cycle

    assign is_write = in.instr.ctl.memwrite;
    assign is_read  = in.instr.ctl.memtoreg;
    assign bus_en   = is_read | is_write;

    assign fetch_fault = in.exception_instr | in.instr_tlb_invalid | in.instr_tlb_refill;

    // misaligned accesses, byte ops never fault
    assign pipe.exc_info.load = ((op == OP_LW) && (addr[1:0] != 2'b00)) ||
                                ((op == OP_LH || op == OP_LHU) && addr[0]);
    assign pipe.exc_info.save = ((op == OP_SW) && (addr[1:0] != 2'b00)) ||
                                ((op == OP_SH) && addr[0]);
    assign pipe.exc_info.sys  = (op == OP_SYSCALL);
    assign pipe.exc_info.bp   = (op == OP_BREAK);

    assign pipe.exc_info.instr     = in.exception_instr;
    assign pipe.exc_info.instr_tlb = in.instr_tlb_invalid | in.instr_tlb_refill;
    assign pipe.exc_info.ri        = in.exception_ri;
    assign pipe.exc_info.of        = in.exception_of;

    // a refill miss is reported with the same code as an invalid entry
    assign pipe.exc_info.load_tlb = (tu_op_resp.d_tlb_invalid | tu_op_resp.d_tlb_refill) & is_read;
    assign pipe.exc_info.save_tlb = (tu_op_resp.d_tlb_invalid | tu_op_resp.d_tlb_refill) & is_write;
    assign pipe.exc_info.mod      = tu_op_resp.d_tlb_modified & is_write;
    assign pipe.tlb_refill        = in.instr_tlb_refill | (tu_op_resp.d_tlb_refill & bus_en);

    assign pipe.in_delay_slot  = in.in_delay_slot;
    assign pipe.pc             = in.pcplus4 - 32'd4;
    assign pipe.vaddr          = fetch_fault ? pipe.pc : in.result;
    assign pipe.interrupt_info = ({ext_int, 2'b00} | cp0_cause.IP | {timer_interrupt, 7'b0})
                                 & cp0_status.IM;

    exception_prioritizer exception_prioritizer_i (
        .pipe            (pipe),
        .cp0_status      (cp0_status),
        .exception_valid (raw_valid),
        .pcexception     (raw_vector),
        .exception       (raw_exception)
    );

    assign exception_valid = take & raw_valid;
    assign pcexception     = take ? raw_vector : '0;
    assign exception_data  = take ? raw_exception : '0;
    assign out             = (take && !raw_valid) ? in : '0;
    assign eret_valid      = take & ~raw_valid & (op == OP_ERET);

endmodule

/* src/cp0_regs.sv */
module cp0_regs
    import mips_exc_pkg::*;
#(
    parameter logic RESET_BEV = 1'b1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        exc_commit,
    input  exception_t  exc,
    input  logic        eret_commit,
    input  cp0_write_t  cp0_wr,
    input  logic [4:0]  raddr,
    input  logic [5:0]  ext_int,
    output word_t       rdata,
    output cp0_status_t status,
    output cp0_cause_t  cause,
    output word_t       epc,
    output logic        timer_interrupt
);

    word_t badvaddr;
    word_t count;
    word_t compare;
    logic  sw_en;
    logic  wr_compare;

    // a commit in the same cycle drops the software write
    assign sw_en      = cp0_wr.en & ~exc_commit & ~eret_commit;
    assign wr_compare = sw_en && (cp0_wr.addr == REG_COMPARE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status.BEV <= RESET_BEV;
            status.IM  <= '0;
            status.EXL <= 1'b0;
            status.IE  <= 1'b0;
            cause      <= '0;
            count      <= '0;
            compare    <= 32'hffff_ffff;  // keeps the timer quiet out of reset
        end else begin
            cause.IP[7:2] <= ext_int;

            if (sw_en && cp0_wr.addr == REG_COUNT) begin
                count <= cp0_wr.data;
            end else begin
                count <= count + 32'd1;
            end

            if (wr_compare) begin
                compare  <= cp0_wr.data;
                cause.TI <= 1'b0;
            end else if (count == compare) begin
                cause.TI <= 1'b1;
            end

            if (sw_en && cp0_wr.addr == REG_CAUSE) begin
                cause.IP[1:0] <= cp0_wr.data[9:8];
            end

            if (exc_commit) begin
                status.EXL     <= 1'b1;
                cause.BD       <= exc.in_delay_slot;
                cause.exc_code <= exc.code;
            end else if (eret_commit) begin
                status.EXL <= 1'b0;
            end else if (sw_en && cp0_wr.addr == REG_STATUS) begin
                status.BEV <= cp0_wr.data[22];
                status.IM  <= cp0_wr.data[15:8];
                status.EXL <= cp0_wr.data[1];
                status.IE  <= cp0_wr.data[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit) begin
            epc <= exc.in_delay_slot ? exc.pc - 32'd4 : exc.pc;  // restart at the branch
            if (exc.has_bad_vaddr) begin
                badvaddr <= exc.bad_vaddr;
            end
        end else if (sw_en && cp0_wr.addr == REG_EPC) begin
            epc <= cp0_wr.data;
        end
    end

    assign timer_interrupt = cause.TI;

    always_comb begin
        case (raddr)
            REG_BADVADDR: rdata = badvaddr;
            REG_COUNT:    rdata = count;
            REG_COMPARE:  rdata = compare;
            REG_STATUS:   rdata = {9'b0, status.BEV, 6'b0, status.IM, 6'b0, status.EXL, status.IE};
            REG_CAUSE:    rdata = {cause.BD, cause.TI, 14'b0, cause.IP, 1'b0, cause.exc_code, 2'b0};
            REG_EPC:      rdata = epc;
            default:      rdata = '0;
        endcase
    end

endmodule

/* src/exc_control.sv */
module exc_control
    import mips_exc_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  exception_valid,
    input  word_t pcexception,
    input  logic  eret_valid,
    input  word_t epc,
    output logic  exc_commit,
    output logic  eret_commit,
    output logic  pipe_flush,
    output logic  redirect_valid,
    output word_t redirect_pc
);

    ctl_state_t state;
    ctl_state_t state_next;
    word_t      target;

    always_comb begin
        exc_commit  = 1'b0;
        eret_commit = 1'b0;
        state_next  = state;
        case (state)
            CTL_RUN: begin
                exc_commit  = exception_valid;
                eret_commit = eret_valid & ~exception_valid;
                if (exception_valid || eret_valid) begin
                    state_next = CTL_FLUSH;
                end
            end
            CTL_FLUSH: begin
                state_next = CTL_RUN;  // events here are ignored
            end
            default: begin
                state_next = CTL_RUN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CTL_RUN;
        end else begin
            state <= state_next;
        end
    end

    // epc is sampled before cp0 updates on the same edge
    always_ff @(posedge clk) begin
        if (exc_commit || eret_commit) begin
            target <= exc_commit ? pcexception : epc;
        end
    end

    assign pipe_flush     = (state == CTL_FLUSH);
    assign redirect_valid = (state == CTL_FLUSH);
    assign redirect_pc    = target;

endmodule

/* src/exc_stage_top.sv */
module exc_stage_top
    import mips_exc_pkg::*;
#(
    parameter logic RESET_BEV = 1'b1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  exec_data_t  mem_in,
    input  tu_op_resp_t tu_op_resp,
    input  logic [5:0]  ext_int,
    input  cp0_write_t  cp0_wr,
    input  logic [4:0]  cp0_raddr,
    output word_t       cp0_rdata,
    output logic        exception_valid,
    output word_t       pcexception,
    output exception_t  exception_data,
    output exec_data_t  mem_out,
    output logic        pipe_flush,
    output logic        redirect_valid,
    output word_t       redirect_pc
);

    cp0_status_t cp0_status;
    cp0_cause_t  cp0_cause;
    word_t       epc;
    logic        timer_interrupt;
    logic        eret_valid;
    logic        exc_commit;
    logic        eret_commit;

    exception_checker exception_checker_i (
        .flush           (flush),
        .in              (mem_in),
        .ext_int         (ext_int),
        .timer_interrupt (timer_interrupt),
        .cp0_status      (cp0_status),
        .cp0_cause       (cp0_cause),
        .tu_op_resp      (tu_op_resp),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .exception_data  (exception_data),
        .out             (mem_out),
        .eret_valid      (eret_valid)
    );

    cp0_regs #(
        .RESET_BEV (RESET_BEV)
    ) cp0_regs_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .exc_commit      (exc_commit),
        .exc             (exception_data),
        .eret_commit     (eret_commit),
        .cp0_wr          (cp0_wr),
        .raddr           (cp0_raddr),
        .ext_int         (ext_int),
        .rdata           (cp0_rdata),
        .status          (cp0_status),
        .cause           (cp0_cause),
        .epc             (epc),
        .timer_interrupt (timer_interrupt)
    );

    exc_control exc_control_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .eret_valid      (eret_valid),
        .epc             (epc),
        .exc_commit      (exc_commit),
        .eret_commit     (eret_commit),
        .pipe_flush      (pipe_flush),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

endmodule

/* tb/exc_stage_tb.sv */
module exc_stage_tb
    import mips_exc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ADDR     = 100;
    localparam int N_PRIO     = 120;
    localparam int MAX_CYCLES = 2 * ((N_ADDR + N_PRIO) * 6 + 200);  // six cycles per test at most

    logic        clk;
    logic        rst_n;
    logic        flush;
    exec_data_t  mem_in;
    tu_op_resp_t tu_op_resp;
    logic [5:0]  ext_int;
    cp0_write_t  cp0_wr;
    logic [4:0]  cp0_raddr;
    word_t       cp0_rdata;
    logic        exception_valid;
    word_t       pcexception;
    exception_t  exception_data;
    exec_data_t  mem_out;
    logic        pipe_flush;
    logic        redirect_valid;
    word_t       redirect_pc;

    integer      seed;
    int          cycles = 0;
    logic        exl_model;   // Status.EXL as the testbench expects it
    word_t       last_epc;

    exc_stage_top #(
        .RESET_BEV (1'b0)
    ) exc_stage_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .mem_in          (mem_in),
        .tu_op_resp      (tu_op_resp),
        .ext_int         (ext_int),
        .cp0_wr          (cp0_wr),
        .cp0_raddr       (cp0_raddr),
        .cp0_rdata       (cp0_rdata),
        .exception_valid (exception_valid),
        .pcexception     (pcexception),
        .exception_data  (exception_data),
        .mem_out         (mem_out),
        .pipe_flush      (pipe_flush),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string test, input string what, input logic [95:0] exp,
                         input logic [95:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %0h, actual %0h", test, what, exp, act);
            $display("TEST FAILED");
            $fatal(1, "%s stopped the run", test);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic cp0_write(input logic [4:0] addr, input word_t data);
        cp0_wr.en   = 1'b1;
        cp0_wr.addr = addr;
        cp0_wr.data = data;
        tick();
        cp0_wr = '0;
    endtask

    task automatic cp0_read(input logic [4:0] addr, output word_t data);
        cp0_raddr = addr;
        #1;
        data = cp0_rdata;
    endtask

    task automatic set_status(input logic [7:0] im, input logic ie, input logic exl);
        cp0_write(REG_STATUS, {16'b0, im, 6'b0, exl, ie});  // BEV stays 0
        exl_model = exl;
    endtask

    function automatic decoded_op_t mem_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return OP_LW;
            3'd1:    return OP_LH;
            3'd2:    return OP_LHU;
            3'd3:    return OP_LB;
            3'd4:    return OP_LBU;
            3'd5:    return OP_SW;
            3'd6:    return OP_SH;
            default: return OP_SB;
        endcase
    endfunction

    function automatic decoded_op_t prio_op(input logic [2:0] sel);
        case (sel)
            3'd1:    return OP_SYSCALL;
            3'd2:    return OP_BREAK;
            3'd3:    return OP_LW;
            3'd4:    return OP_SW;
            3'd5:    return OP_LH;
            3'd6:    return OP_SH;
            default: return OP_ALU;
        endcase
    endfunction

    function automatic exec_data_t make_instr(input decoded_op_t op, input word_t pcplus4,
                                              input word_t result, input logic ds);
        exec_data_t m;
        m                    = '0;
        m.valid              = 1'b1;
        m.instr.op           = op;
        m.instr.ctl.memtoreg = (op == OP_LW) || (op == OP_LH) || (op == OP_LHU) ||
                               (op == OP_LB) || (op == OP_LBU);
        m.instr.ctl.memwrite = (op == OP_SW) || (op == OP_SH) || (op == OP_SB);
        m.pcplus4            = pcplus4;
        m.result             = result;
        m.in_delay_slot      = ds;
        return m;
    endfunction

    // reference model of the exception priority
    task automatic predict(input exec_data_t m, input tu_op_resp_t t, input logic irq,
                           output logic hit, output exc_code_t code,
                           output logic fetch_side, output logic refill);
        int   align;
        logic mis;
        logic dmiss;
        logic ld;
        logic st;
        case (m.instr.op)
            OP_LW, OP_SW:         align = 4;
            OP_LH, OP_LHU, OP_SH: align = 2;
            default:              align = 1;
        endcase
        ld         = m.instr.ctl.memtoreg;
        st         = m.instr.ctl.memwrite;
        mis        = (m.result % align) != 0;
        dmiss      = t.d_tlb_refill | t.d_tlb_invalid;
        hit        = 1'b1;
        fetch_side = 1'b0;
        refill     = 1'b0;
        code       = EXC_INT;
        if (irq) begin
            code = EXC_INT;
        end else if (m.exception_instr) begin
            code       = EXC_ADEL;
            fetch_side = 1'b1;
        end else if (m.instr_tlb_refill || m.instr_tlb_invalid) begin
            code       = EXC_TLBL;
            fetch_side = 1'b1;
            refill     = m.instr_tlb_refill;
        end else if (m.exception_ri) begin
            code = EXC_RI;
        end else if (m.exception_of) begin
            code = EXC_OV;
        end else if (m.instr.op == OP_SYSCALL) begin
            code = EXC_SYS;
        end else if (m.instr.op == OP_BREAK) begin
            code = EXC_BP;
        end else if (mis && ld) begin
            code = EXC_ADEL;
        end else if (mis && st) begin
            code = EXC_ADES;
        end else if (dmiss && ld) begin
            code   = EXC_TLBL;
            refill = t.d_tlb_refill;
        end else if (dmiss && st) begin
            code   = EXC_TLBS;
            refill = t.d_tlb_refill;
        end else if (t.d_tlb_modified && st) begin
            code = EXC_MOD;
        end else begin
            hit = 1'b0;
        end
    endtask

    task automatic apply(input string test, input exec_data_t m, input tu_op_resp_t t,
                         input logic irq);
        logic       hit;
        logic       fetch_side;
        logic       refill;
        logic       has_bad;
        exc_code_t  code;
        word_t      pc;
        word_t      vec;
        word_t      epc_exp;
        word_t      rd;
        word_t      bad_before;
        exec_data_t exp_out;
        predict(m, t, irq, hit, code, fetch_side, refill);
        pc      = m.pcplus4 - 32'd4;
        epc_exp = m.in_delay_slot ? pc - 32'd4 : pc;
        vec     = VEC_BASE_BEV0 + ((refill && !exl_model) ? OFS_REFILL : OFS_GENERAL);
        has_bad = hit && (code == EXC_ADEL || code == EXC_ADES || code == EXC_TLBL ||
                          code == EXC_TLBS || code == EXC_MOD);
        exp_out = hit ? '0 : m;
        cp0_read(REG_BADVADDR, bad_before);
        mem_in     = m;
        tu_op_resp = t;
        #5;
        check(test, "exception_valid", hit, exception_valid);
        check(test, "mem_out", exp_out, mem_out);
        if (hit) begin
            check(test, "cause code", code, exception_data.code);
            check(test, "has_bad_vaddr", has_bad, exception_data.has_bad_vaddr);
            check(test, "refill", refill, exception_data.refill);
            check(test, "vector", vec, pcexception);
        end
        tick();
        mem_in     = '0;
        tu_op_resp = '0;
        check(test, "pipe_flush", hit, pipe_flush);
        check(test, "redirect_valid", hit, redirect_valid);
        if (hit) begin
            check(test, "redirect_pc", vec, redirect_pc);
            tick();
            check(test, "pipe_flush after one cycle", 1'b0, pipe_flush);
            check(test, "redirect_valid after one cycle", 1'b0, redirect_valid);
            cp0_read(REG_EPC, rd);
            check(test, "EPC", epc_exp, rd);
            cp0_read(REG_CAUSE, rd);
            check(test, "Cause.BD", m.in_delay_slot, rd[31]);
            check(test, "Cause.ExcCode", code, rd[6:2]);
            cp0_read(REG_BADVADDR, rd);
            if (has_bad) begin
                check(test, "BadVAddr", fetch_side ? pc : m.result, rd);
            end else begin
                check(test, "BadVAddr unchanged", bad_before, rd);
            end
            exl_model = 1'b1;
            last_epc  = epc_exp;
        end
    endtask

    task automatic check_suppressed(input string test, input exec_data_t m, input logic fl);
        word_t epc_before;
        word_t cause_before;
        word_t rd;
        cp0_read(REG_EPC, epc_before);
        cp0_read(REG_CAUSE, cause_before);
        mem_in     = m;
        flush      = fl;
        tu_op_resp = '0;
        #5;
        check(test, "exception_valid", 1'b0, exception_valid);
        check(test, "vector", 32'd0, pcexception);
        check(test, "exception_data", '0, exception_data);
        check(test, "mem_out", '0, mem_out);
        tick();
        mem_in = '0;
        flush  = 1'b0;
        check(test, "pipe_flush", 1'b0, pipe_flush);
        cp0_read(REG_EPC, rd);
        check(test, "EPC unchanged", epc_before, rd);
        cp0_read(REG_CAUSE, rd);
        check(test, "Cause unchanged", cause_before, rd);
    endtask

    task automatic eret_check(input string test, input exec_data_t m);
        word_t rd;
        mem_in = m;
        #5;
        check(test, "exception_valid", 1'b0, exception_valid);
        check(test, "mem_out", m, mem_out);
        tick();
        mem_in = '0;
        check(test, "pipe_flush", 1'b1, pipe_flush);
        check(test, "redirect_valid", 1'b1, redirect_valid);
        check(test, "redirect_pc", last_epc, redirect_pc);
        tick();
        check(test, "redirect_valid after one cycle", 1'b0, redirect_valid);
        cp0_read(REG_STATUS, rd);
        check(test, "Status.EXL", 1'b0, rd[1]);
        exl_model = 1'b0;
    endtask

    initial begin
        word_t       r;
        word_t       pc4;
        word_t       res;
        word_t       rd;
        exec_data_t  m;
        tu_op_resp_t t;
        int          i;
        int          wait_cycles;
        seed       = 32'hb9ea_a69b;
        rst_n      = 1'b0;
        flush      = 1'b0;
        mem_in     = '0;
        tu_op_resp = '0;
        ext_int    = '0;
        cp0_wr     = '0;
        cp0_raddr  = '0;
        exl_model  = 1'b0;
        last_epc   = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check("reset", "exception_valid", 1'b0, exception_valid);
        check("reset", "pipe_flush", 1'b0, pipe_flush);
        check("reset", "redirect_valid", 1'b0, redirect_valid);
        cp0_read(REG_STATUS, rd);
        check("reset", "Status", 32'd0, rd);
        cp0_read(REG_CAUSE, rd);
        check("reset", "Cause", 32'd0, rd);

        t = '0;
        for (i = 0; i < N_ADDR; i++) begin
            r   = $random(seed);
            pc4 = $random(seed);
            res = $random(seed);
            pc4[1:0] = 2'b00;
            if (r[3]) res[1:0] = 2'b00;  // about half aligned
            m = make_instr(mem_op(r[2:0]), pc4, res, r[4]);
            apply("address_error", m, t, 1'b0);
            set_status(8'h00, 1'b0, 1'b0);
        end

        for (i = 0; i < N_PRIO; i++) begin
            r   = $random(seed);
            pc4 = $random(seed);
            res = $random(seed);
            pc4[1:0] = 2'b00;
            m = make_instr(prio_op(r[2:0]), pc4, res, r[16]);
            m.exception_instr   = (r[5:4] == 2'b00);
            m.instr_tlb_invalid = (r[7:6] == 2'b00);
            m.exception_ri      = (r[9:8] == 2'b00);
            m.exception_of      = (r[11:10] == 2'b00);
            t                   = '0;
            t.d_tlb_invalid     = (r[13:12] == 2'b00);
            t.d_tlb_modified    = (r[15:14] == 2'b00);
            apply("priority", m, t, 1'b0);
            set_status(8'h00, 1'b0, 1'b0);
        end

        t = '0;
        t.d_tlb_refill = 1'b1;
        m = make_instr(OP_LW, 32'h0040_1004, 32'h1000_2000, 1'b0);
        apply("tlb_refill_exl_clear", m, t, 1'b0);
        apply("tlb_refill_exl_set", m, t, 1'b0);  // EXL left set by the previous one
        set_status(8'h00, 1'b0, 1'b0);
        t = '0;
        t.d_tlb_invalid = 1'b1;
        apply("tlb_invalid_load", m, t, 1'b0);
        set_status(8'h00, 1'b0, 1'b0);
        m = make_instr(OP_SW, 32'h0040_2008, 32'h1000_3004, 1'b1);
        apply("tlb_invalid_store", m, t, 1'b0);
        set_status(8'h00, 1'b0, 1'b0);
        t = '0;
        t.d_tlb_modified = 1'b1;
        apply("tlb_modified", m, t, 1'b0);

        eret_check("eret", make_instr(OP_ERET, 32'h0040_3000, 32'd0, 1'b0));

        m = make_instr(OP_LW, 32'h0040_4000, 32'h1000_0003, 1'b0);
        m.valid = 1'b0;
        check_suppressed("suppress_invalid", m, 1'b0);
        m.valid = 1'b1;
        check_suppressed("suppress_flush", m, 1'b1);

        t = '0;
        set_status(8'hff, 1'b1, 1'b0);
        m = make_instr(OP_ALU, 32'h0040_5000, 32'h1234_5678, 1'b0);
        ext_int = 6'b000100;
        apply("irq_external", m, t, 1'b1);
        apply("irq_exl_set", m, t, 1'b0);
        set_status(8'hff, 1'b0, 1'b0);
        apply("irq_ie_clear", m, t, 1'b0);
        ext_int = '0;
        tick();  // let the hardware IP bits clear
        set_status(8'h80, 1'b1, 1'b0);
        cp0_read(REG_COUNT, rd);
        cp0_write(REG_COMPARE, rd + 32'd16);
        wait_cycles = 0;
        cp0_read(REG_CAUSE, rd);
        while (!rd[30]) begin
            if (wait_cycles == 64) begin
                $display("timer interrupt was not raised within 64 cycles of the Compare write");
                $display("TEST FAILED");
                $fatal(1, "timer interrupt missing");
            end
            tick();
            wait_cycles++;
            cp0_read(REG_CAUSE, rd);
        end
        apply("irq_timer", m, t, 1'b1);
        cp0_write(REG_COMPARE, 32'hffff_ffff);
        set_status(8'h00, 1'b0, 1'b0);

        tick();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tb.f */
src/mips_exc_pkg.sv
src/exception_prioritizer.sv
src/exception_checker.sv
src/cp0_regs.sv
src/exc_control.sv
src/exc_stage_top.sv
tb/exc_stage_tb.sv
